// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
        -Mdir obj_dir -f tb.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vtb_core); then
    echo "$out"
    echo "Simulation exited with an error"
    exit 1
fi
echo "$out"

if grep -qx "Done: no errors" <<< "$out"; then
    exit 0
fi
exit 1

// ==== source/alu_cmp.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu_cmp
    import rv32i_pkg::*;
(
    input  wire alu_ops         aluop,
    input  wire logic    [31:0] a,
    input  wire logic    [31:0] b,
    output logic         [31:0] alu_out,
    input  wire branch_funct3_t cmpop,
    input  wire logic    [31:0] c1,
    input  wire logic    [31:0] c2,
    output logic                br_en
);

    always_comb begin
        // Shift amounts come from the low five bits of the second operand.
        case (aluop)
            alu_add: alu_out = a + b;
            alu_sll: alu_out = a << b[4:0];
            alu_sra: alu_out = $unsigned($signed(a) >>> b[4:0]);
            alu_sub: alu_out = a - b;
            alu_xor: alu_out = a ^ b;
            alu_srl: alu_out = a >> b[4:0];
            alu_or:  alu_out = a | b;
            alu_and: alu_out = a & b;
            default: alu_out = a + b;
        endcase
    end

    always_comb begin
        case (cmpop)
            beq:     br_en = (c1 == c2);
            bne:     br_en = (c1 != c2);
            blt:     br_en = ($signed(c1) < $signed(c2));
            bge:     br_en = ($signed(c1) >= $signed(c2));
            bltu:    br_en = (c1 < c2);
            bgeu:    br_en = (c1 >= c2);
            default: br_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/control.sv ====
`default_nettype none
`timescale 1ns/1ps

module control
    import rv32i_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire dp_status_t status,
    input  wire logic       mem_resp,
    output ctrl_t           ctrl,
    output logic            mem_read,
    output logic            mem_write
);

    typedef enum logic [3:0] {
        FETCH1, FETCH2, FETCH3, DECODE,
        LUI, AUIPC, JAL, JALR, BR, IMM, REG,
        CALC_ADDR, LD1, LD2, ST1, ST2
    } state_t;

    state_t        state;
    state_t        next_state;
    arith_funct3_t arith_funct3;
    load_funct3_t  load_funct3;

    assign arith_funct3 = arith_funct3_t'(status.funct3);
    assign load_funct3  = load_funct3_t'(status.funct3);

    // Idle control word. The ALU and comparator ops follow funct3 unless a state overrides them.
    function automatic ctrl_t ctrl_defaults(logic [2:0] funct3);
        ctrl_t c;
        c                = '0;
        c.pcmux_sel      = pcmux_pc_plus4;
        c.alumux1_sel    = alumux1_rs1_out;
        c.alumux2_sel    = alumux2_i_imm;
        c.regfilemux_sel = rfmux_alu_out;
        c.marmux_sel     = marmux_pc_out;
        c.cmpmux_sel     = cmpmux_rs2_out;
        c.aluop          = alu_ops'(funct3);
        c.cmpop          = branch_funct3_t'(funct3);
        case (store_funct3_t'(funct3))
            sw:      c.wmask = 4'b1111;
            sh:      c.wmask = 4'b0011;
            sb:      c.wmask = 4'b0001;
            default: c.wmask = 4'b0000;
        endcase
        return c;
    endfunction

    always_comb begin : state_actions
        ctrl      = ctrl_defaults(status.funct3);
        mem_read  = 1'b0;
        mem_write = 1'b0;

        unique case (state)
            FETCH1: begin
                ctrl.load_mar   = 1'b1;
                ctrl.marmux_sel = marmux_pc_out;
            end
            FETCH2, LD1: begin
                mem_read      = 1'b1;
                ctrl.load_mdr = 1'b1;
            end
            FETCH3: ctrl.load_ir = 1'b1;
            DECODE: begin
                // An unknown opcode is skipped, so the PC still moves on.
                case (status.opcode)
                    op_lui, op_auipc, op_jal, op_jalr, op_br,
                    op_imm, op_reg, op_load, op_store: ;
                    default: ctrl.load_pc = 1'b1;
                endcase
            end
            LUI: begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rfmux_u_imm;
                ctrl.load_pc        = 1'b1;
            end
            AUIPC: begin
                ctrl.alumux1_sel  = alumux1_pc_out;
                ctrl.alumux2_sel  = alumux2_u_imm;
                ctrl.aluop        = alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_pc      = 1'b1;
            end
            JAL, JALR: begin
                ctrl.alumux1_sel    = (state == JAL) ? alumux1_pc_out : alumux1_rs1_out;
                ctrl.alumux2_sel    = (state == JAL) ? alumux2_j_imm : alumux2_i_imm;
                ctrl.aluop          = alu_add;
                ctrl.pcmux_sel      = (state == JAL) ? pcmux_alu_out : pcmux_alu_mod2;
                ctrl.load_pc        = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = rfmux_pc_plus4;
            end
            BR: begin
                // The ALU forms the target while the comparator decides.
                ctrl.alumux1_sel = alumux1_pc_out;
                ctrl.alumux2_sel = alumux2_b_imm;
                ctrl.aluop       = alu_add;
                ctrl.cmpmux_sel  = cmpmux_rs2_out;
                ctrl.pcmux_sel   = pcmux_sel_t'({1'b0, status.br_en});
                ctrl.load_pc     = 1'b1;
            end
            IMM, REG: begin
                ctrl.alumux2_sel  = (state == IMM) ? alumux2_i_imm : alumux2_rs2_out;
                ctrl.cmpmux_sel   = (state == IMM) ? cmpmux_i_imm : cmpmux_rs2_out;
                ctrl.load_regfile = 1'b1;
                ctrl.load_pc      = 1'b1;
                case (arith_funct3)
                    slt: begin
                        ctrl.cmpop          = blt;
                        ctrl.regfilemux_sel = rfmux_br_en;
                    end
                    sltu: begin
                        ctrl.cmpop          = bltu;
                        ctrl.regfilemux_sel = rfmux_br_en;
                    end
                    sr: ctrl.aluop = status.funct7[5] ? alu_sra : alu_srl;
                    add: begin
                        if (state == REG && status.funct7[5]) begin
                            ctrl.aluop = alu_sub;
                        end
                    end
                    default: ;
                endcase
            end
            CALC_ADDR: begin
                ctrl.aluop      = alu_add;
                ctrl.load_mar   = 1'b1;
                ctrl.marmux_sel = marmux_alu_out;
                if (status.opcode == op_store) begin
                    ctrl.alumux2_sel   = alumux2_s_imm;
                    ctrl.load_data_out = 1'b1;
                end
            end
            LD2: begin
                ctrl.load_pc      = 1'b1;
                ctrl.load_regfile = 1'b1;
                case (load_funct3)
                    lb:      ctrl.regfilemux_sel = rfmux_lb;
                    lbu:     ctrl.regfilemux_sel = rfmux_lbu;
                    lh:      ctrl.regfilemux_sel = rfmux_lh;
                    lhu:     ctrl.regfilemux_sel = rfmux_lhu;
                    lw:      ctrl.regfilemux_sel = rfmux_lw;
                    default: ctrl.load_regfile = 1'b0;
                endcase
            end
            ST1: mem_write = 1'b1;
            ST2: ctrl.load_pc = 1'b1;
            default: ;
        endcase
    end

    always_comb begin : next_state_logic
        unique case (state)
            FETCH1: next_state = FETCH2;
            FETCH2: next_state = mem_resp ? FETCH3 : FETCH2;
            FETCH3: next_state = DECODE;
            DECODE: begin
                case (status.opcode)
                    op_lui:             next_state = LUI;
                    op_auipc:           next_state = AUIPC;
                    op_jal:             next_state = JAL;
                    op_jalr:            next_state = JALR;
                    op_br:              next_state = BR;
                    op_imm:             next_state = IMM;
                    op_reg:             next_state = REG;
                    op_load, op_store:  next_state = CALC_ADDR;
                    default:            next_state = FETCH1;
                endcase
            end
            CALC_ADDR: next_state = (status.opcode == op_store) ? ST1 : LD1;
            LD1: next_state = mem_resp ? LD2 : LD1;
            ST1: next_state = mem_resp ? ST2 : ST1;
            default: next_state = FETCH1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH1;
        end else begin
            state <= next_state;
        end
    end

    no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write));

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
`default_nettype none
`timescale 1ns/1ps

module datapath
    import rv32i_pkg::*;
#(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire ctrl_t       ctrl,
    input  wire logic        mem_read,
    input  wire logic        mem_write,
    input  wire logic [31:0] mem_rdata,
    output dp_status_t       status,
    output mem_req_t         mem_req
);

    logic [31:0] pc, ir, mar, mdr, data_out;
    logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [31:0] rs1_out, rs2_out, alu_a, alu_b, alu_out, cmp_b;
    logic [31:0] pc_plus4, pc_next, mar_next, rf_in, ld_word;
    logic        br_en;

    assign i_imm    = {{21{ir[31]}}, ir[30:20]};
    assign s_imm    = {{21{ir[31]}}, ir[30:25], ir[11:7]};
    assign b_imm    = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign u_imm    = {ir[31:12], 12'h000};
    assign j_imm    = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
    assign pc_plus4 = pc + 32'd4;

    // Loaded bytes and halves are brought down to bit 0 by the address offset.
    assign ld_word = mdr >> {mar[1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (ctrl.load_pc) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_ir) ir <= mdr;
        if (ctrl.load_mar) mar <= mar_next;
        if (ctrl.load_mdr) mdr <= mem_rdata;
        if (ctrl.load_data_out) data_out <= rs2_out;
    end

    always_comb begin
        alu_a    = (ctrl.alumux1_sel == alumux1_pc_out) ? pc : rs1_out;
        cmp_b    = (ctrl.cmpmux_sel == cmpmux_i_imm) ? i_imm : rs2_out;
        mar_next = (ctrl.marmux_sel == marmux_alu_out) ? alu_out : pc;
        case (ctrl.alumux2_sel)
            alumux2_u_imm:   alu_b = u_imm;
            alumux2_b_imm:   alu_b = b_imm;
            alumux2_s_imm:   alu_b = s_imm;
            alumux2_j_imm:   alu_b = j_imm;
            alumux2_rs2_out: alu_b = rs2_out;
            default:         alu_b = i_imm;
        endcase
        case (ctrl.pcmux_sel)
            pcmux_alu_out:  pc_next = alu_out;
            pcmux_alu_mod2: pc_next = {alu_out[31:1], 1'b0};
            default:        pc_next = pc_plus4;
        endcase
        case (ctrl.regfilemux_sel)
            rfmux_br_en:    rf_in = {31'b0, br_en};
            rfmux_u_imm:    rf_in = u_imm;
            rfmux_lw:       rf_in = mdr;
            rfmux_pc_plus4: rf_in = pc_plus4;
            rfmux_lb:       rf_in = {{24{ld_word[7]}}, ld_word[7:0]};
            rfmux_lbu:      rf_in = {24'b0, ld_word[7:0]};
            rfmux_lh:       rf_in = {{16{ld_word[15]}}, ld_word[15:0]};
            rfmux_lhu:      rf_in = {16'b0, ld_word[15:0]};
            default:        rf_in = alu_out;
        endcase
    end

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .load    (ctrl.load_regfile),
        .rs1     (ir[19:15]),
        .rs2     (ir[24:20]),
        .rd      (ir[11:7]),
        .in_data (rf_in),
        .rs1_out (rs1_out),
        .rs2_out (rs2_out)
    );

    alu_cmp u_alu_cmp (
        .aluop   (ctrl.aluop),
        .a       (alu_a),
        .b       (alu_b),
        .alu_out (alu_out),
        .cmpop   (ctrl.cmpop),
        .c1      (rs1_out),
        .c2      (cmp_b),
        .br_en   (br_en)
    );

    always_comb begin
        status.opcode = rv32i_opcode'(ir[6:0]);
        status.funct3 = ir[14:12];
        status.funct7 = ir[31:25];
        status.br_en  = br_en;
    end

    // Stores shift data and mask into the lanes picked by the low MAR bits.
    always_comb begin
        mem_req.read        = mem_read;
        mem_req.write       = mem_write;
        mem_req.addr        = {mar[31:2], 2'b00};
        mem_req.wdata       = data_out << {mar[1:0], 3'b000};
        mem_req.byte_enable = mem_write ? (ctrl.wmask << mar[1:0]) : 4'b1111;
    end

    addr_aligned: assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) |-> (mem_req.addr[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
`default_nettype none
`timescale 1ns/1ps

module regfile (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        load,
    input  wire logic [4:0]  rs1,
    input  wire logic [4:0]  rs2,
    input  wire logic [4:0]  rd,
    input  wire logic [31:0] in_data,
    output logic      [31:0] rs1_out,
    output logic      [31:0] rs2_out
);

    logic [31:0] data [32];

    // Entry 0 is cleared by reset and never written, so x0 reads zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                data[i] <= '0;
            end
        end else if (load && rd != 5'd0) begin
            data[rd] <= in_data;
        end
    end

    assign rs1_out = data[rs1];
    assign rs2_out = data[rs2];

    x0_zero: assert property (@(posedge clk) disable iff (rst)
        load |=> (data[0] == '0));

endmodule

`default_nettype wire

// ==== source/rv32i_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module rv32i_core
    import rv32i_pkg::*;
#(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  wire logic        clk,
    input  wire logic        rst,
    output mem_req_t         mem_req,
    input  wire logic [31:0] mem_rdata,
    input  wire logic        mem_resp
);

    ctrl_t      ctrl;
    dp_status_t status;
    logic       mem_read;
    logic       mem_write;

    control u_control (
        .clk       (clk),
        .rst       (rst),
        .status    (status),
        .mem_resp  (mem_resp),
        .ctrl      (ctrl),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_rdata (mem_rdata),
        .status    (status),
        .mem_req   (mem_req)
    );

endmodule

`default_nettype wire

// ==== source/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    // Major opcodes of the supported RV32I instruction classes.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq = 3'b000, bne = 3'b001, blt = 3'b100, bge = 3'b101, bltu = 3'b110, bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb = 3'b000, lh = 3'b001, lw = 3'b010, lbu = 3'b100, lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000, sh = 3'b001, sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add = 3'b000, sll = 3'b001, slt = 3'b010, sltu = 3'b011,
        axor = 3'b100, sr = 3'b101, aor = 3'b110, aand = 3'b111
    } arith_funct3_t;

    // Matches arith funct3 for add, sll, xor, srl, or and and.
    typedef enum logic [2:0] {
        alu_add = 3'b000, alu_sll = 3'b001, alu_sra = 3'b010, alu_sub = 3'b011,
        alu_xor = 3'b100, alu_srl = 3'b101, alu_or = 3'b110, alu_and = 3'b111
    } alu_ops;

    // The branch state casts br_en into the low bit of this select.
    typedef enum logic [1:0] {
        pcmux_pc_plus4 = 2'b00, pcmux_alu_out = 2'b01, pcmux_alu_mod2 = 2'b10
    } pcmux_sel_t;

    typedef enum logic {alumux1_rs1_out, alumux1_pc_out} alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm, alumux2_u_imm, alumux2_b_imm,
        alumux2_s_imm, alumux2_j_imm, alumux2_rs2_out
    } alumux2_sel_t;

    typedef enum logic [3:0] {
        rfmux_alu_out, rfmux_br_en, rfmux_u_imm, rfmux_lw, rfmux_pc_plus4,
        rfmux_lb, rfmux_lbu, rfmux_lh, rfmux_lhu
    } regfilemux_sel_t;

    typedef enum logic {marmux_pc_out, marmux_alu_out} marmux_sel_t;

    typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;

    // Control word from the FSM to the datapath.
    typedef struct packed {
        pcmux_sel_t      pcmux_sel;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        regfilemux_sel_t regfilemux_sel;
        marmux_sel_t     marmux_sel;
        cmpmux_sel_t     cmpmux_sel;
        alu_ops          aluop;
        branch_funct3_t  cmpop;
        logic            load_pc;
        logic            load_ir;
        logic            load_regfile;
        logic            load_mar;
        logic            load_mdr;
        logic            load_data_out;
        logic [3:0]      wmask;
    } ctrl_t;

    typedef struct packed {
        rv32i_opcode opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic        br_en;
    } dp_status_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_enable;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== tb.f ====
source/rv32i_pkg.sv
source/regfile.sv
source/alu_cmp.sv
source/control.sv
source/datapath.sv
source/rv32i_core.sv
testbench/tb_mem.sv
testbench/tb_core.sv

// ==== testbench/tb_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_core
    import rv32i_pkg::*;
;

    localparam logic [31:0] RESET_PC  = 32'h0000_0080;
    localparam logic [31:0] HALT_ADDR = 32'h0000_07FC;
    localparam logic [6:0]  OPI       = 7'b0010011;
    localparam logic [6:0]  OPR       = 7'b0110011;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] data;
    } store_rec_t;

    logic        clk;
    logic        rst;
    mem_req_t    mem_req;
    logic [31:0] mem_rdata;
    logic        mem_resp;
    logic        txn_valid;
    mem_req_t    txn;

    logic [31:0] img [512];
    logic [31:0] ref_mem [512];
    logic [31:0] exp_reads [$];
    store_rec_t  exp_stores [$];
    int          wp;
    int          errors;
    int          n_instr;
    logic        ref_ready;
    logic        halted;

    rv32i_core #(.reset_pc(RESET_PC)) DUT (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    tb_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .req       (mem_req),
        .rdata     (mem_rdata),
        .resp      (mem_resp),
        .txn_valid (txn_valid),
        .txn       (txn)
    );

    always #10 clk = ~clk;

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %0t %s expected %08h actual %08h", $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPR};
    endfunction

    function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic put(logic [31:0] w);
        img[wp] = w;
        wp++;
    endtask

    // Builds the program at RESET_PC. Registers x4 = -7 and x5 = 13 feed most tests.
    task automatic build_image();
        int f3s [6];
        int tk1 [6];
        int tk2 [6];
        int nt1 [6];
        int rn;
        f3s = '{0, 1, 4, 5, 6, 7};
        tk1 = '{4, 4, 4, 5, 5, 4};
        tk2 = '{4, 5, 5, 4, 4, 5};
        nt1 = '{5, 4, 5, 4, 4, 5};
        rn  = 0;
        for (int i = 0; i < 512; i++) begin
            img[i] = (i * 32'h9E37_79B1) ^ {i[15:0], ~i[15:0]};
        end
        wp = RESET_PC / 4;
        put(enc_i(1024, 0, 0, 1, OPI));
        put(enc_i(1536, 0, 0, 31, OPI));
        put({20'h80000, 5'd2, 7'b0110111});
        put({20'h00001, 5'd3, 7'b0010111});
        put(enc_i(-7, 0, 0, 4, OPI));
        put(enc_i(13, 0, 0, 5, OPI));
        put(enc_r(7'h00, 5, 4, 0, 6));
        put(enc_r(7'h20, 5, 4, 0, 7));
        put(enc_r(7'h00, 5, 4, 1, 11));
        put(enc_r(7'h00, 5, 4, 2, 14));
        put(enc_r(7'h00, 5, 4, 3, 15));
        put(enc_r(7'h00, 5, 4, 4, 8));
        put(enc_r(7'h00, 5, 4, 5, 12));
        put(enc_r(7'h20, 5, 4, 5, 13));
        put(enc_r(7'h00, 5, 4, 6, 9));
        put(enc_r(7'h00, 5, 4, 7, 10));
        put(enc_i(-3, 4, 2, 16, OPI));
        put(enc_i(-1, 5, 3, 17, OPI));
        put(enc_i(32'h555, 4, 4, 18, OPI));
        put(enc_i(-256, 5, 6, 19, OPI));
        put(enc_i(32'h0F0, 4, 7, 21, OPI));
        put(enc_i(7, 4, 1, 22, OPI));
        put(enc_i(3, 4, 5, 23, OPI));
        put(enc_i(32'h403, 4, 5, 24, OPI));
        put(enc_i(5, 5, 0, 0, OPI));
        put(enc_r(7'h00, 5, 4, 0, 0));
        put(enc_r(7'h00, 5, 0, 0, 25));
        // An opcode the core does not know, which must be skipped.
        put(32'h0000_000F);
        // Each branch once taken and once not, each skipping an increment of x20.
        for (int k = 0; k < 6; k++) begin
            put(enc_b(8, tk2[k], tk1[k], f3s[k]));
            put(enc_i(1, 20, 0, 20, OPI));
            put(enc_b(8, tk1[k], nt1[k], f3s[k]));
            put(enc_i(16, 20, 0, 20, OPI));
        end
        put(enc_i(3, 0, 0, 26, OPI));
        put(enc_i(-1, 26, 0, 26, OPI));
        put(enc_b(-4, 0, 26, 1));
        put(enc_j(8, 27));
        put(enc_i(256, 20, 0, 20, OPI));
        put({20'h00000, 5'd28, 7'b0010111});
        put(enc_i(17, 28, 0, 28, OPI));
        put(enc_i(0, 28, 0, 29, 7'b1100111));
        put(enc_i(256, 20, 0, 20, OPI));
        // Loads at every legal offset, each result stored to the result area.
        for (int f = 0; f < 5; f++) begin
            for (int off = 0; off < 4; off += (f < 2) ? 1 : (f < 4) ? 2 : 4) begin
                put(enc_i(off, 1, (f == 0) ? 0 : (f == 1) ? 4 : (f == 2) ? 1 : (f == 3) ? 5 : 2,
                          30, 7'b0000011));
                put(enc_s(rn * 4, 30, 31, 2));
                rn++;
            end
        end
        for (int off = 0; off < 4; off++) begin
            put(enc_s(32'h100 + off, 4, 1, 0));
        end
        put(enc_s(32'h108, 3, 1, 1));
        put(enc_s(32'h10A, 2, 1, 1));
        put(enc_s(32'h10C, 9, 1, 2));
        for (int r = 0; r < 31; r++) begin
            put(enc_s(32'h40 + 4 * r, r, 31, 2));
        end
        put(enc_s(32'h1FC, 0, 31, 2));
    endtask

    // Interprets the program by RV32I rules and fills the expected read and store queues.
    function automatic int run_reference();
        logic [31:0] x [32];
        logic [31:0] pc, ins, npc, a, op2, v, w;
        logic [31:0] iimm, simm, bimm, jimm;
        logic [4:0]  rd, rs1, rs2;
        logic [3:0]  bm;
        logic [2:0]  f3;
        logic        wen, take, halt;
        int          n;
        store_rec_t  s;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc   = RESET_PC;
        halt = 1'b0;
        n    = 0;
        while (!halt && n < 4000) begin
            ins = ref_mem[pc[10:2]];
            exp_reads.push_back(pc);
            rd   = ins[11:7];
            rs1  = ins[19:15];
            rs2  = ins[24:20];
            f3   = ins[14:12];
            iimm = {{20{ins[31]}}, ins[31:20]};
            simm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            bimm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            jimm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            npc  = pc + 4;
            wen  = 1'b0;
            v    = '0;
            case (ins[6:0])
                7'b0110111: begin
                    wen = 1'b1;
                    v   = {ins[31:12], 12'b0};
                end
                7'b0010111: begin
                    wen = 1'b1;
                    v   = pc + {ins[31:12], 12'b0};
                end
                7'b1101111: begin
                    wen = 1'b1;
                    v   = pc + 4;
                    npc = pc + jimm;
                end
                7'b1100111: begin
                    wen = 1'b1;
                    v   = pc + 4;
                    npc = (x[rs1] + iimm) & ~32'd1;
                end
                7'b1100011: begin
                    case (f3)
                        3'd0:    take = (x[rs1] == x[rs2]);
                        3'd1:    take = (x[rs1] != x[rs2]);
                        3'd4:    take = ($signed(x[rs1]) < $signed(x[rs2]));
                        3'd5:    take = ($signed(x[rs1]) >= $signed(x[rs2]));
                        3'd6:    take = (x[rs1] < x[rs2]);
                        3'd7:    take = (x[rs1] >= x[rs2]);
                        default: take = 1'b0;
                    endcase
                    if (take) begin
                        npc = pc + bimm;
                    end
                end
                7'b0000011: begin
                    a = x[rs1] + iimm;
                    exp_reads.push_back({a[31:2], 2'b00});
                    w   = ref_mem[a[10:2]] >> {a[1:0], 3'b000};
                    wen = 1'b1;
                    case (f3)
                        3'd0:    v = {{24{w[7]}}, w[7:0]};
                        3'd4:    v = {24'b0, w[7:0]};
                        3'd1:    v = {{16{w[15]}}, w[15:0]};
                        3'd5:    v = {16'b0, w[15:0]};
                        default: v = w;
                    endcase
                end
                7'b0100011: begin
                    a      = x[rs1] + simm;
                    bm     = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
                    s.addr = {a[31:2], 2'b00};
                    s.be   = bm << a[1:0];
                    s.data = x[rs2] << {a[1:0], 3'b000};
                    exp_stores.push_back(s);
                    for (int b = 0; b < 4; b++) begin
                        if (s.be[b]) begin
                            ref_mem[a[10:2]][8*b +: 8] = s.data[8*b +: 8];
                        end
                    end
                    halt = (s.addr == HALT_ADDR);
                end
                7'b0010011, 7'b0110011: begin
                    a   = x[rs1];
                    op2 = ins[5] ? x[rs2] : iimm;
                    wen = 1'b1;
                    case (f3)
                        3'd0:    v = (ins[5] && ins[30]) ? a - op2 : a + op2;
                        3'd1:    v = a << op2[4:0];
                        3'd2:    v = {31'b0, $signed(a) < $signed(op2)};
                        3'd3:    v = {31'b0, a < op2};
                        3'd4:    v = a ^ op2;
                        3'd5:    v = ins[30] ? $unsigned($signed(a) >>> op2[4:0]) : a >> op2[4:0];
                        3'd6:    v = a | op2;
                        default: v = a & op2;
                    endcase
                end
                default: ;
            endcase
            if (wen && rd != 5'd0) begin
                x[rd] = v;
            end
            pc = npc;
            n++;
        end
        return n;
    endfunction

    // Every completed transaction is compared with the next expected read or store.
    always @(posedge clk) begin
        store_rec_t  s;
        logic [31:0] m;
        if (!rst && txn_valid) begin
            if (txn.read) begin
                if (exp_reads.size() == 0) begin
                    $display("The core read address %08h after the last expected read", txn.addr);
                    errors++;
                end else begin
                    check("read_addr", exp_reads.pop_front(), txn.addr);
                end
            end else if (exp_stores.size() == 0) begin
                $display("The core stored to %08h after the last expected store", txn.addr);
                errors++;
            end else begin
                s = exp_stores.pop_front();
                m = {{8{s.be[3]}}, {8{s.be[2]}}, {8{s.be[1]}}, {8{s.be[0]}}};
                check("store_addr", s.addr, txn.addr);
                check("store_byte_enable", {28'b0, s.be}, {28'b0, txn.byte_enable});
                check("store_wdata", s.data & m, txn.wdata & m);
                if (txn.addr == HALT_ADDR) begin
                    halted = 1'b1;
                end
            end
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        errors    = 0;
        halted    = 1'b0;
        ref_ready = 1'b0;
        build_image();
        for (int i = 0; i < 512; i++) begin
            ref_mem[i]    = img[i];
            u_mem.mem[i]  = img[i];
        end
        n_instr   = run_reference();
        ref_ready = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        wait (halted);
        @(negedge clk);
        for (int i = 0; i < 512; i++) begin
            check($sformatf("mem[%0d]", i), ref_mem[i], u_mem.mem[i]);
        end
        if (exp_reads.size() != 0 || exp_stores.size() != 0) begin
            $display("The run ended with expected reads or stores that never happened");
            errors++;
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Allows 15 cycles per instruction of the reference run, plus the reset.
    initial begin
        wait (ref_ready);
        #((n_instr * 15 + 2) * 20);
        $display("Timeout: the core did not reach the halt store in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_mem.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_mem
    import rv32i_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire mem_req_t req,
    output logic [31:0]   rdata,
    output logic          resp,
    output logic          txn_valid,
    output mem_req_t      txn
);

    logic [31:0] mem [512];
    integer      seed;
    int          wait_left;
    logic        busy;

    initial begin
        seed      = 99;
        rdata     = '0;
        resp      = 1'b0;
        txn_valid = 1'b0;
        txn       = '0;
        busy      = 1'b0;
        wait_left = 0;
    end

    // The memory acts on the falling edge, so the core sees a stable response at its rising edge.
    // Each request waits a random 0 to 3 cycles before the one-cycle response.
    always @(negedge clk) begin
        if (rst) begin
            resp      <= 1'b0;
            txn_valid <= 1'b0;
            busy = 1'b0;
        end else if (resp) begin
            resp      <= 1'b0;
            txn_valid <= 1'b0;
        end else if (req.read || req.write) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = int'({$random(seed)} % 4);
            end
            if (wait_left == 0) begin
                busy = 1'b0;
                resp      <= 1'b1;
                txn_valid <= 1'b1;
                txn       <= req;
                if (req.read) begin
                    rdata <= mem[req.addr[10:2]];
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (req.byte_enable[b]) begin
                            mem[req.addr[10:2]][8*b +: 8] = req.wdata[8*b +: 8];
                        end
                    end
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

endmodule

`default_nettype wire
